/* compile.f */
logic/wb_stream_pkg.sv
logic/wb_addr_decode.sv
logic/stream_queue.sv
logic/wb_stream_bridge.sv
logic/stream_accumulator.sv
logic/wb_accel_top.sv
dv/wb_accel_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the wishbone accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module wb_accel_tb \
  -Mdir obj_dir -o wb_accel_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/wb_accel_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

/* dv/wb_accel_tb.sv */
// testbench for the wishbone accelerator subsystem
// random bus traffic checked against a per-lane queue and running-sum model
`default_nettype none

module wb_accel_tb;

  import wb_stream_pkg::*;

  // words one lane absorbs with no host reads: input queue, accumulator, output queue
  localparam int PIPE_CAP = 2 * QUEUE_DEPTH + 1;
  localparam int POLL_MAX = 200;

  logic       clk;
  logic       reset_i;
  logic       wbs_stb_i;
  logic       wbs_cyc_i;
  logic       wbs_we_i;
  logic [3:0] wbs_sel_i;
  word_t      wbs_adr_i;
  word_t      wbs_dat_i;
  logic       wbs_ack_o;
  word_t      wbs_dat_o;

  // model state per lane
  word_t run_sum [NUM_ISTREAM];
  word_t exp_q   [NUM_ISTREAM][$];

  int status_errs;
  int data_errs;
  int ack_errs;
  int timeout_errs;

  wb_accel_top u_dut (
    .clk       (clk),
    .reset_i   (reset_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // address map and compare tasks
  //////////////////////////////////////////////////
  function automatic word_t ist_adr(input int lane, input logic [2:0] ofs);
    return ISTREAM_BASE + word_t'(lane * CHAN_STRIDE) + word_t'(ofs);
  endfunction

  function automatic word_t ost_adr(input int lane, input logic [2:0] ofs);
    return OSTREAM_BASE + word_t'(lane * CHAN_STRIDE) + word_t'(ofs);
  endfunction

  task automatic check_status(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH @%0t %s: status %h, expected %h", $time, what, got, exp);
      status_errs++;
    end
  endtask

  task automatic check_data(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH @%0t %s: data %h, expected %h", $time, what, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_ack(input logic got, input string what);
    if (got !== 1'b1) begin
      $display("MISMATCH @%0t %s: ack %b, expected 1", $time, what, got);
      ack_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // single-cycle bus accesses
  //////////////////////////////////////////////////
  task automatic bus_idle();
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_sel_i = 4'h0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
  endtask

  task automatic bus_write(input word_t adr, input word_t dat);
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i  = 1'b1;
    wbs_sel_i = 4'hf;
    wbs_adr_i = adr;
    wbs_dat_i = dat;
    #2;
    check_ack(wbs_ack_o, "write");
    @(posedge clk);
    #1;
    bus_idle();
  endtask

  // read data is combinational, sampled mid-cycle
  task automatic bus_read(input word_t adr, output word_t dat);
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i  = 1'b0;
    wbs_sel_i = 4'hf;
    wbs_adr_i = adr;
    #2;
    dat = wbs_dat_o;
    check_ack(wbs_ack_o, "read");
    @(posedge clk);
    #1;
    bus_idle();
  endtask

  task automatic wait_status(input word_t adr, input word_t exp, input string what);
    word_t got;
    int    tries;
    tries = 0;
    bus_read(adr, got);
    while (got !== exp && tries < POLL_MAX) begin
      bus_read(adr, got);
      tries++;
    end
    if (got !== exp) begin
      $display("timeout: %s did not read %0h within %0d polls", what, exp, POLL_MAX);
      timeout_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // model-driven traffic
  //////////////////////////////////////////////////
  task automatic push_word(input int lane, input word_t w);
    wait_status(ist_adr(lane, STATUS_OFS), 1, $sformatf("lane %0d input status", lane));
    bus_write(ist_adr(lane, DATA_OFS), w);
    run_sum[lane] = run_sum[lane] + w;
    exp_q[lane].push_back(run_sum[lane]);
  endtask

  task automatic pop_result(input int lane);
    word_t got;
    word_t exp;
    wait_status(ost_adr(lane, STATUS_OFS), 1, $sformatf("lane %0d output status", lane));
    bus_read(ost_adr(lane, DATA_OFS), got);
    exp = (exp_q[lane].size() > 0) ? exp_q[lane].pop_front() : '0;
    check_data(got, exp, $sformatf("lane %0d result", lane));
  endtask

  task automatic random_traffic(input int n_ops);
    int lane;
    repeat (n_ops) begin
      lane = int'($urandom % NUM_ISTREAM);
      if (exp_q[lane].size() < PIPE_CAP && ($urandom % 3) != 0) begin
        push_word(lane, $urandom);
      end else if (exp_q[lane].size() > 0) begin
        pop_result(lane);
      end
    end
  endtask

  task automatic drain_lanes();
    for (int lane = 0; lane < NUM_ISTREAM; lane++) begin
      while (exp_q[lane].size() > 0) begin
        pop_result(lane);
      end
    end
  endtask

  // fill one lane until the host sees no room, then show extra words are lost
  task automatic check_backpressure(input int lane);
    word_t got;
    repeat (PIPE_CAP) push_word(lane, $urandom);
    wait_status(ist_adr(lane, STATUS_OFS), 0, "input status under back-pressure");
    repeat (20) begin
      bus_read(ist_adr(lane, STATUS_OFS), got);
      check_status(got, 0, "stalled input status");
    end
    // whole lane stalled, both words dropped
    repeat (2) bus_write(ist_adr(lane, DATA_OFS), $urandom);
    repeat (PIPE_CAP) pop_result(lane);
    repeat (10) begin
      bus_read(ost_adr(lane, STATUS_OFS), got);
      check_status(got, 0, "output status after drain");
    end
  endtask

  task automatic check_unmapped();
    word_t got;
    for (int lane = 0; lane < NUM_ISTREAM; lane++) begin
      bus_write(ist_adr(lane, STATUS_OFS), $urandom);
      bus_write(ost_adr(lane, STATUS_OFS), $urandom);
      bus_write(ost_adr(lane, DATA_OFS), $urandom);
      bus_read(ist_adr(lane, DATA_OFS), got);
      check_data(got, 0, "input data read");
    end
    bus_write(OSTREAM_END, $urandom);
    bus_read(OSTREAM_END, got);
    check_data(got, 0, "unmapped read");
    repeat (8) begin
      for (int lane = 0; lane < NUM_ISTREAM; lane++) begin
        bus_read(ist_adr(lane, STATUS_OFS), got);
        check_status(got, 1, "input status after stray writes");
        bus_read(ost_adr(lane, STATUS_OFS), got);
        check_status(got, 0, "output status after stray writes");
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    word_t got;
    void'($urandom(7));
    clk          = 1'b0;
    reset_i      = 1'b1;
    status_errs  = 0;
    data_errs    = 0;
    ack_errs     = 0;
    timeout_errs = 0;
    bus_idle();
    for (int lane = 0; lane < NUM_ISTREAM; lane++) begin
      run_sum[lane] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;

    for (int lane = 0; lane < NUM_ISTREAM; lane++) begin
      bus_read(ist_adr(lane, STATUS_OFS), got);
      check_status(got, 1, "input status after reset");
      bus_read(ost_adr(lane, STATUS_OFS), got);
      check_status(got, 0, "output status after reset");
    end

    // running sum, one word at a time
    repeat (6) begin
      push_word(0, $urandom);
      pop_result(0);
    end

    check_backpressure(1);

    // lanes interleaved at random
    random_traffic(200);
    drain_lanes();

    // empty read, then a normal result
    bus_read(ost_adr(0, DATA_OFS), got);
    check_data(got, 0, "empty output read");
    push_word(0, $urandom);
    pop_result(0);

    check_unmapped();
    random_traffic(100);
    drain_lanes();

    $display("errors: status %0d, data %0d, ack %0d, timeout %0d",
             status_errs, data_errs, ack_errs, timeout_errs);
    if (status_errs + data_errs + ack_errs + timeout_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/wb_accel_top.sv */
// wishbone accelerator top
// stream bridge plus one accumulator lane per channel pair
`default_nettype none

module wb_accel_top (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 wbs_stb_i,
  input  logic                 wbs_cyc_i,
  input  logic                 wbs_we_i,
  input  logic [3:0]           wbs_sel_i,
  input  wb_stream_pkg::word_t wbs_adr_i,
  input  wb_stream_pkg::word_t wbs_dat_i,
  output logic                 wbs_ack_o,
  output wb_stream_pkg::word_t wbs_dat_o
);

  import wb_stream_pkg::*;

  logic [NUM_ISTREAM-1:0] ist_val;
  logic [NUM_ISTREAM-1:0] ist_rdy;
  word_t                  ist_data [NUM_ISTREAM];
  logic [NUM_OSTREAM-1:0] ost_val;
  logic [NUM_OSTREAM-1:0] ost_rdy;
  word_t                  ost_data [NUM_OSTREAM];

  wb_stream_bridge u_bridge (
    .clk            (clk),
    .reset_i        (reset_i),
    .wbs_stb_i      (wbs_stb_i),
    .wbs_cyc_i      (wbs_cyc_i),
    .wbs_we_i       (wbs_we_i),
    .wbs_sel_i      (wbs_sel_i),
    .wbs_adr_i      (wbs_adr_i),
    .wbs_dat_i      (wbs_dat_i),
    .wbs_ack_o      (wbs_ack_o),
    .wbs_dat_o      (wbs_dat_o),
    .istream_val_o  (ist_val),
    .istream_rdy_i  (ist_rdy),
    .istream_data_o (ist_data),
    .ostream_val_i  (ost_val),
    .ostream_rdy_o  (ost_rdy),
    .ostream_data_i (ost_data)
  );

  //////////////////////////////////////////////////
  // lanes
  //////////////////////////////////////////////////
  for (genvar i = 0; i < NUM_ISTREAM; i++) begin : g_lane
    stream_accumulator u_acc (
      .clk        (clk),
      .reset_i    (reset_i),
      .in_val_i   (ist_val[i]),
      .in_rdy_o   (ist_rdy[i]),
      .in_data_i  (ist_data[i]),
      .out_val_o  (ost_val[i]),
      .out_rdy_i  (ost_rdy[i]),
      .out_data_o (ost_data[i])
    );
  end

endmodule

`default_nettype wire

/* logic/stream_accumulator.sv */
// accelerator lane: running 32-bit sum over its input stream
// each accepted word yields one held result on the output stream
`default_nettype none

module stream_accumulator (
  input  logic                 clk,
  input  logic                 reset_i,

  input  logic                 in_val_i,
  output logic                 in_rdy_o,
  input  wb_stream_pkg::word_t in_data_i,

  output logic                 out_val_o,
  input  logic                 out_rdy_i,
  output wb_stream_pkg::word_t out_data_o
);

  import wb_stream_pkg::*;

  word_t sum_q;
  logic  out_val_q;
  logic  in_fire;
  logic  out_fire;

  // free slot, or the held result leaves this cycle
  assign in_rdy_o = !out_val_q || out_rdy_i;

  assign in_fire  = in_val_i && in_rdy_o;
  assign out_fire = out_val_q && out_rdy_i;

  assign out_val_o  = out_val_q;
  assign out_data_o = sum_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sum_q     <= '0;
      out_val_q <= 1'b0;
    end else begin
      if (in_fire) begin
        // wraps mod 2^32
        sum_q     <= sum_q + in_data_i;
        out_val_q <= 1'b1;
      end else if (out_fire) begin
        out_val_q <= 1'b0;
      end
    end
  end

  // result held steady under back-pressure
  a_hold_result: assert property (@(posedge clk) disable iff (reset_i)
    (out_val_o && !out_rdy_i) |=> (out_val_o && $stable(out_data_o)));

endmodule

`default_nettype wire

/* logic/wb_stream_bridge.sv */
// wishbone slave bridging the bus to per-lane stream queues
// input queues take host writes and output queues hold lane results for readback
`default_nettype none

module wb_stream_bridge (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 wbs_stb_i,
  input  logic                 wbs_cyc_i,
  input  logic                 wbs_we_i,
  input  logic [3:0]           wbs_sel_i,
  input  wb_stream_pkg::word_t wbs_adr_i,
  input  wb_stream_pkg::word_t wbs_dat_i,
  output logic                 wbs_ack_o,
  output wb_stream_pkg::word_t wbs_dat_o,

  // host to lane
  output logic [wb_stream_pkg::NUM_ISTREAM-1:0] istream_val_o,
  input  logic [wb_stream_pkg::NUM_ISTREAM-1:0] istream_rdy_i,
  output wb_stream_pkg::word_t istream_data_o [wb_stream_pkg::NUM_ISTREAM],

  // lane to host
  input  logic [wb_stream_pkg::NUM_OSTREAM-1:0] ostream_val_i,
  output logic [wb_stream_pkg::NUM_OSTREAM-1:0] ostream_rdy_o,
  input  wb_stream_pkg::word_t ostream_data_i [wb_stream_pkg::NUM_OSTREAM]
);

  import wb_stream_pkg::*;

  logic [NUM_ISTREAM-1:0] ist_wr;
  logic [NUM_ISTREAM-1:0] ist_enq_rdy;
  logic [NUM_OSTREAM-1:0] ost_rd;
  logic [NUM_OSTREAM-1:0] ost_deq_val;
  word_t                  ost_deq_msg [NUM_OSTREAM];
  rsel_t                  rsel;
  chan_idx_t              rchan;

  // every access is a full word so wbs_sel_i is not decoded
  assign wbs_ack_o = wbs_stb_i && wbs_cyc_i;

  wb_addr_decode u_decode (
    .clk       (clk),
    .reset_i   (reset_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_adr_i (wbs_adr_i),
    .ist_wr_o  (ist_wr),
    .ost_rd_o  (ost_rd),
    .rsel_o    (rsel),
    .rchan_o   (rchan)
  );

  //////////////////////////////////////////////////
  // queue arrays
  //////////////////////////////////////////////////
  for (genvar i = 0; i < NUM_ISTREAM; i++) begin : g_ist_queue
    stream_queue u_ist_queue (
      .clk       (clk),
      .reset_i   (reset_i),
      .enq_val_i (ist_wr[i]),
      .enq_rdy_o (ist_enq_rdy[i]),
      .enq_msg_i (wbs_dat_i),
      .deq_val_o (istream_val_o[i]),
      .deq_rdy_i (istream_rdy_i[i]),
      .deq_msg_o (istream_data_o[i])
    );
  end

  for (genvar j = 0; j < NUM_OSTREAM; j++) begin : g_ost_queue
    stream_queue u_ost_queue (
      .clk       (clk),
      .reset_i   (reset_i),
      .enq_val_i (ostream_val_i[j]),
      .enq_rdy_o (ostream_rdy_o[j]),
      .enq_msg_i (ostream_data_i[j]),
      .deq_val_o (ost_deq_val[j]),
      .deq_rdy_i (ost_rd[j]),
      .deq_msg_o (ost_deq_msg[j])
    );
  end

  // read mux where an empty output queue reads back as zero
  always_comb begin
    case (rsel)
      RSEL_IST_STATUS: wbs_dat_o = word_t'(ist_enq_rdy[rchan]);
      RSEL_OST_STATUS: wbs_dat_o = word_t'(ost_deq_val[rchan]);
      RSEL_OST_DATA:   wbs_dat_o = ost_deq_val[rchan] ? ost_deq_msg[rchan] : '0;
      default:         wbs_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/stream_queue.sv */
// val/rdy FIFO of QUEUE_DEPTH words
// circular buffer with read/write pointers and an occupancy count
`default_nettype none

module stream_queue (
  input  logic                 clk,
  input  logic                 reset_i,

  input  logic                 enq_val_i,
  output logic                 enq_rdy_o,
  input  wb_stream_pkg::word_t enq_msg_i,

  output logic                 deq_val_o,
  input  logic                 deq_rdy_i,
  output wb_stream_pkg::word_t deq_msg_o
);

  import wb_stream_pkg::*;

  word_t mem [QUEUE_DEPTH];
  qptr_t wr_ptr;
  qptr_t rd_ptr;
  qcnt_t count;
  logic  full;
  logic  empty;
  logic  enq_fire;
  logic  deq_fire;

  assign full  = (count == qcnt_t'(QUEUE_DEPTH));
  assign empty = (count == '0);

  assign enq_rdy_o = !full;
  assign deq_val_o = !empty;
  assign deq_msg_o = mem[rd_ptr];

  assign enq_fire = enq_val_i && enq_rdy_o;
  assign deq_fire = deq_val_o && deq_rdy_i;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_msg_i;
    end
  end

  //////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous enq and deq leave the count alone
      if (enq_fire && !deq_fire) begin
        count <= count + 1'b1;
      end else if (deq_fire && !enq_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  // an enqueue attempt on a full queue is dropped, head untouched
  a_full_drop: assert property (@(posedge clk) disable iff (reset_i)
    (enq_val_i && full && !deq_fire) |=> (full && $stable(deq_msg_o)));

  a_count_bound: assert property (@(posedge clk) disable iff (reset_i)
    count <= qcnt_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* logic/wb_addr_decode.sv */
// wishbone address decoder for the stream channels
// turns one bus cycle into enqueue/dequeue strobes and a read-mux select
`default_nettype none

module wb_addr_decode (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        wbs_stb_i,
  input  logic                        wbs_cyc_i,
  input  logic                        wbs_we_i,
  input  wb_stream_pkg::word_t        wbs_adr_i,
  output logic [wb_stream_pkg::NUM_ISTREAM-1:0] ist_wr_o,
  output logic [wb_stream_pkg::NUM_OSTREAM-1:0] ost_rd_o,
  output wb_stream_pkg::rsel_t        rsel_o,
  output wb_stream_pkg::chan_idx_t    rchan_o
);

  import wb_stream_pkg::*;

  logic      txn_val;
  logic      in_ist;
  logic      in_ost;
  word_t     ist_ofs;
  word_t     ost_ofs;
  chan_idx_t ist_chan;
  chan_idx_t ost_chan;
  logic      ist_data_wr;
  logic      ost_data_rd;

  assign txn_val = wbs_stb_i && wbs_cyc_i;

  //////////////////////////////////////////////////
  // range check and channel extraction
  //////////////////////////////////////////////////
  assign in_ist = (wbs_adr_i >= ISTREAM_BASE) && (wbs_adr_i < OSTREAM_BASE);
  assign in_ost = (wbs_adr_i >= OSTREAM_BASE) && (wbs_adr_i < OSTREAM_END);

  assign ist_ofs  = wbs_adr_i - ISTREAM_BASE;
  assign ost_ofs  = wbs_adr_i - OSTREAM_BASE;
  assign ist_chan = ist_ofs[CHAN_LSB +: CHAN_BITS];
  assign ost_chan = ost_ofs[CHAN_LSB +: CHAN_BITS];

  // data offset writes go to input queues, reads come from output queues
  assign ist_data_wr = txn_val && wbs_we_i && in_ist && (ist_ofs[2:0] == DATA_OFS);
  assign ost_data_rd = txn_val && !wbs_we_i && in_ost && (ost_ofs[2:0] == DATA_OFS);

  for (genvar i = 0; i < NUM_ISTREAM; i++) begin : g_ist_wr
    assign ist_wr_o[i] = ist_data_wr && (ist_chan == chan_idx_t'(i));
  end

  for (genvar j = 0; j < NUM_OSTREAM; j++) begin : g_ost_rd
    assign ost_rd_o[j] = ost_data_rd && (ost_chan == chan_idx_t'(j));
  end

  //////////////////////////////////////////////////
  // read-data select
  //////////////////////////////////////////////////
  always_comb begin
    rsel_o  = RSEL_NONE;
    rchan_o = '0;
    if (txn_val && !wbs_we_i) begin
      if (in_ist && (ist_ofs[2:0] == STATUS_OFS)) begin
        rsel_o  = RSEL_IST_STATUS;
        rchan_o = ist_chan;
      end else if (in_ost && (ost_ofs[2:0] == STATUS_OFS)) begin
        rsel_o  = RSEL_OST_STATUS;
        rchan_o = ost_chan;
      end else if (ost_data_rd) begin
        rsel_o  = RSEL_OST_DATA;
        rchan_o = ost_chan;
      end
    end
  end

  // a bus cycle touches at most one queue
  a_one_strobe: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({ist_wr_o, ost_rd_o}));

endmodule

`default_nettype wire

/* logic/wb_stream_pkg.sv */
// wishbone stream subsystem shared definitions
// address map, channel counts, queue sizing and the bus word
`default_nettype none

package wb_stream_pkg;

  // bus and stream data word
  typedef logic [31:0] word_t;

  // one input and one output channel per lane
  localparam int NUM_ISTREAM = 2;
  localparam int NUM_OSTREAM = 2;
  localparam int QUEUE_DEPTH = 2;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////
  localparam int         CHAN_STRIDE  = 8;
  localparam int         CHAN_LSB     = $clog2(CHAN_STRIDE);
  localparam word_t      ISTREAM_BASE = 32'h3000_0000;
  localparam word_t      OSTREAM_BASE = ISTREAM_BASE + NUM_ISTREAM * CHAN_STRIDE;
  localparam word_t      OSTREAM_END  = OSTREAM_BASE + NUM_OSTREAM * CHAN_STRIDE;
  localparam logic [2:0] STATUS_OFS   = 3'd0;
  localparam logic [2:0] DATA_OFS     = 3'd4;

  // channel index sized for the larger side
  localparam int NUM_CHAN_MAX = (NUM_ISTREAM > NUM_OSTREAM) ? NUM_ISTREAM : NUM_OSTREAM;
  localparam int CHAN_BITS    = (NUM_CHAN_MAX > 1) ? $clog2(NUM_CHAN_MAX) : 1;
  typedef logic [CHAN_BITS-1:0] chan_idx_t;

  // queue pointer and occupancy widths
  localparam int QPTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int QCNT_BITS = $clog2(QUEUE_DEPTH + 1);
  typedef logic [QPTR_BITS-1:0] qptr_t;
  typedef logic [QCNT_BITS-1:0] qcnt_t;

  // read-data source picked by the address decoder
  typedef enum logic [1:0] {
    RSEL_NONE,
    RSEL_IST_STATUS,
    RSEL_OST_STATUS,
    RSEL_OST_DATA
  } rsel_t;

endpackage

`default_nettype wire
